/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := sd_spi_tb
FILELIST  := all.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
design/zx_bus_pkg.sv
design/sd_spi_pkg.sv
design/sd_port_decoder.sv
design/spi_tx_fifo.sv
design/spi_master.sv
design/sd_spi_top.sv
verification/sd_spi_tb.sv

/* design/sd_port_decoder.sv */
`timescale 1ns/1ps

module sd_port_decoder (
	input  logic               fclk,
	input  logic               rst_n,

	// synchronised Z80 io strobes
	input  logic               io_wr,
	input  logic               io_rd,
	input  logic [15:0]        a,
	input  zx_bus_pkg::zbyte_t din,
	output zx_bus_pkg::zbyte_t dout,
	output logic               dout_ena,

	// transmit queue
	output logic               push,
	output zx_bus_pkg::zbyte_t push_data,
	input  logic               full,
	input  logic               empty,

	// SPI master side
	input  logic               active,
	input  logic               rx_valid,
	input  zx_bus_pkg::zbyte_t rx_data,

	output logic               sdcs_n
);

	import zx_bus_pkg::*;
	import sd_spi_pkg::*;

	port_op_e op;
	zbyte_t   rx_byte;
	zbyte_t   status;
	logic     ovf;

	// only the low address byte selects the port
	always_comb begin
		op = PORT_NONE;
		if (io_wr) begin
			if (a[7:0] == SD_DATA_PORT)
				op = PORT_DATA_WR;
			else if (a[7:0] == SD_CTRL_PORT)
				op = PORT_CTRL_WR;
		end else if (io_rd) begin
			if (a[7:0] == SD_DATA_PORT)
				op = PORT_DATA_RD;
			else if (a[7:0] == SD_CTRL_PORT)
				op = PORT_CTRL_RD;
		end
	end

	always_comb begin
		status = '0;
		status[STAT_BUSY_BIT] = !empty || active;
		status[STAT_OVF_BIT]  = ovf;
	end

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			push     <= 1'b0;
			dout_ena <= 1'b0;
			sdcs_n   <= 1'b1;
			ovf      <= 1'b0;
			rx_byte  <= IDLE_BYTE;
		end else begin
			// both data port accesses start a transfer
			push     <= (op == PORT_DATA_WR) || (op == PORT_DATA_RD);
			dout_ena <= (op == PORT_DATA_RD) || (op == PORT_CTRL_RD);

			if (op == PORT_CTRL_WR)
				sdcs_n <= din[0];

			// a lost byte outweighs a simultaneous clear
			if (push && full)
				ovf <= 1'b1;
			else if (op == PORT_CTRL_WR)
				ovf <= 1'b0;

			if (rx_valid)
				rx_byte <= rx_data;
		end
	end

	always_ff @(posedge fclk) begin
		push_data <= (op == PORT_DATA_WR) ? din : IDLE_BYTE;
		// a data read sees the byte from before its own transfer
		dout <= (op == PORT_DATA_RD) ? rx_byte : status;
	end

endmodule

/* design/sd_spi_pkg.sv */
package sd_spi_pkg;

	// shifter state
	typedef enum logic {
		SPI_IDLE,
		SPI_SHIFT
	} spi_state_e;

	// status byte layout, the other bits read as zero
	localparam int STAT_BUSY_BIT = 0;
	localparam int STAT_OVF_BIT  = 1;

	// bits per transfer
	localparam int SPI_BITS = 8;

	// fclk cycles per phase cycle, one SPI bit each
	localparam int PHASES = 4;

endpackage

/* design/sd_spi_top.sv */
`timescale 1ns/1ps

module sd_spi_top #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic               fclk,
	input  logic               rst_n,

	// z80 io, already synchronised
	input  logic               io_wr,
	input  logic               io_rd,
	input  logic [15:0]        a,
	input  zx_bus_pkg::zbyte_t din,
	output zx_bus_pkg::zbyte_t dout,
	output logic               dout_ena,

	// sdcard
	output logic               sdcs_n,
	output logic               sdclk,
	output logic               sddo,
	input  logic               sddi
);

	import zx_bus_pkg::*;

	logic   push;
	zbyte_t push_data;
	logic   pop;
	zbyte_t pop_data;
	logic   full;
	logic   empty;
	logic   active;
	logic   rx_valid;
	zbyte_t rx_data;

	sd_port_decoder sd_port_decoder
	(
		.fclk(fclk),
		.rst_n(rst_n),
		.io_wr(io_wr),
		.io_rd(io_rd),
		.a(a),
		.din(din),
		.dout(dout),
		.dout_ena(dout_ena),
		.push(push),
		.push_data(push_data),
		.full(full),
		.empty(empty),
		.active(active),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.sdcs_n(sdcs_n)
	);

	spi_tx_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) spi_tx_fifo
	(
		.fclk(fclk),
		.rst_n(rst_n),
		.push(push),
		.push_data(push_data),
		.pop(pop),
		.pop_data(pop_data),
		.full(full),
		.empty(empty)
	);

	spi_master spi_master
	(
		.fclk(fclk),
		.rst_n(rst_n),
		.empty(empty),
		.pop_data(pop_data),
		.pop(pop),
		.active(active),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.sdclk(sdclk),
		.sddo(sddo),
		.sddi(sddi)
	);

endmodule

/* design/spi_master.sv */
`timescale 1ns/1ps

module spi_master (
	input  logic               fclk,
	input  logic               rst_n,

	// transmit queue
	input  logic               empty,
	input  zx_bus_pkg::zbyte_t pop_data,
	output logic               pop,

	// towards the port decoder
	output logic               active,
	output logic               rx_valid,
	output zx_bus_pkg::zbyte_t rx_data,

	// card pins
	output logic               sdclk,
	output logic               sddo,
	input  logic               sddi
);

	import zx_bus_pkg::*;
	import sd_spi_pkg::*;

	localparam int PH_W  = $clog2(PHASES);
	localparam int CNT_W = $clog2(SPI_BITS);

	spi_state_e       state;
	logic [PH_W-1:0]  ph;
	logic             c0;
	logic             c2;
	logic [CNT_W-1:0] bit_cnt;
	logic             last_bit;
	zbyte_t           sr;

	// free running phase, c0 opens a bit and c2 is its middle
	assign c0 = (ph == '0);
	assign c2 = (ph == PH_W'(PHASES / 2));

	assign last_bit = (bit_cnt == CNT_W'(SPI_BITS - 1));

	// next byte is taken only at a bit boundary
	assign pop    = (state == SPI_IDLE) && !empty && c0;
	assign active = (state == SPI_SHIFT);

	// received bits have replaced the sent ones by the end
	assign rx_data = sr;

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			ph       <= '0;
			state    <= SPI_IDLE;
			bit_cnt  <= '0;
			sdclk    <= 1'b0;
			sddo     <= 1'b1;
			rx_valid <= 1'b0;
		end else begin
			ph       <= ph + 1'b1;
			rx_valid <= 1'b0;

			case (state)
				SPI_IDLE: begin
					if (pop) begin
						state   <= SPI_SHIFT;
						bit_cnt <= '0;
						sddo    <= pop_data[SPI_BITS-1];
					end
				end

				SPI_SHIFT: begin
					if (c2) begin
						sdclk <= 1'b1;
					end else if (c0) begin
						sdclk <= 1'b0;
						if (last_bit) begin
							state    <= SPI_IDLE;
							rx_valid <= 1'b1;
							sddo     <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							sddo    <= sr[SPI_BITS-1];
						end
					end
				end

				default: state <= SPI_IDLE;
			endcase
		end
	end

	// one register shifts out MSB first and shifts the reply in
	always_ff @(posedge fclk) begin
		if (pop)
			sr <= pop_data;
		else if ((state == SPI_SHIFT) && c2)
			sr <= {sr[SPI_BITS-2:0], sddi};
	end

endmodule

/* design/spi_tx_fifo.sv */
`timescale 1ns/1ps

module spi_tx_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic               fclk,
	input  logic               rst_n,

	input  logic               push,
	input  zx_bus_pkg::zbyte_t push_data,

	input  logic               pop,
	output zx_bus_pkg::zbyte_t pop_data,

	output logic               full,
	output logic               empty
);

	import zx_bus_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	zbyte_t           mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// a pop in the same cycle frees the slot for a push
	assign full  = (count == CNT_W'(FIFO_DEPTH)) && !pop;
	assign empty = (count == '0);

	// requests that cannot be served are ignored
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// head is visible without a read cycle
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// pointers wrap by hand so any depth works
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge fclk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

/* design/zx_bus_pkg.sv */
package zx_bus_pkg;

	// one byte on the Z80 data bus
	typedef logic [7:0] zbyte_t;

	// low address bytes of the SD ports, high byte is not decoded
	localparam zbyte_t SD_DATA_PORT = 8'h57;
	localparam zbyte_t SD_CTRL_PORT = 8'h77;

	// byte clocked out by a data port read
	localparam zbyte_t IDLE_BYTE = 8'hFF;

	// what a single io strobe means to the SD link
	typedef enum logic [2:0] {
		PORT_NONE,
		PORT_DATA_WR,
		PORT_DATA_RD,
		PORT_CTRL_WR,
		PORT_CTRL_RD
	} port_op_e;

endpackage

/* verification/sd_spi_input.txt */
// kind value expected, hex; kinds 1 data wr, 2 data rd, 3 ctrl wr, 4 status rd,
// 5 burst, 6 wait idle, 7 check sent byte, 8 status rd with address high byte = value
04 00 00
03 00 00
03 01 01
03 00 00
01 3c 00
07 00 3c
06 00 00
02 00 a5
04 00 01
07 00 ff
06 00 00
02 00 99
07 00 ff
06 00 00
05 00 02
04 00 02
03 00 00
04 00 00
08 a5 00
08 12 00
01 81 00
07 00 81

/* verification/sd_spi_tb.sv */
`timescale 1ns/1ps

module sd_spi_tb;

	import zx_bus_pkg::*;
	import sd_spi_pkg::*;

	localparam int TB_FIFO_DEPTH = 4;
	localparam int MAX_RECS      = 64;
	localparam int POLL_LIMIT    = 200;

	// record kinds beyond the port operations
	localparam int K_BURST   = 5;
	localparam int K_IDLE    = 6;
	localparam int K_TX      = 7;
	localparam int K_STAT_HI = 8;

	logic        fclk;
	logic        rst_n;
	logic        io_wr;
	logic        io_rd;
	logic [15:0] a;
	zbyte_t      din;
	zbyte_t      dout;
	logic        dout_ena;
	logic        sdcs_n;
	logic        sdclk;
	logic        sddo;
	logic        sddi;

	zbyte_t      recs [3*MAX_RECS];
	int          n_recs;
	logic        recs_loaded;
	zbyte_t      tx_q [$];
	logic [31:0] lcg_state;

	// card side state
	zbyte_t      rx_shift;
	int          rx_cnt;
	zbyte_t      reply;

	sd_spi_top #(
		.FIFO_DEPTH(TB_FIFO_DEPTH)
	) uut (
		.fclk(fclk),
		.rst_n(rst_n),
		.io_wr(io_wr),
		.io_rd(io_rd),
		.a(a),
		.din(din),
		.dout(dout),
		.dout_ena(dout_ena),
		.sdcs_n(sdcs_n),
		.sdclk(sdclk),
		.sddo(sddo),
		.sddi(sddi)
	);

	always #5 fclk = ~fclk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_byte(input string name, input zbyte_t exp, input zbyte_t act);
		if (exp !== act)
			stop_run($sformatf("** Error at %0t: %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act)
			stop_run($sformatf("** Error at %0t: %s expected %b got %b", $time, name, exp, act));
	endtask

	task automatic check_state(input string name, input spi_state_e exp, input spi_state_e act);
		if (exp !== act)
			stop_run($sformatf("** Error at %0t: %s expected %s got %s",
				$time, name, exp.name(), act.name()));
	endtask

	// card model replies with the previous received byte xor a5
	always @(posedge sdclk) begin
		rx_shift = {rx_shift[6:0], sddo};
		rx_cnt = rx_cnt + 1;
		if (rx_cnt == SPI_BITS) begin
			tx_q.push_back(rx_shift);
			rx_cnt = 0;
			reply = rx_shift ^ 8'hA5;
		end
	end

	// next reply bit goes out shortly after sck falls
	always @(negedge sdclk) begin
		#1;
		sddi = reply[SPI_BITS - 1 - rx_cnt];
	end

	task automatic port_write(input logic [15:0] addr, input zbyte_t val);
		io_wr = 1'b1;
		a = addr;
		din = val;
		@(posedge fclk);
		#1;
		io_wr = 1'b0;
	endtask

	// dout is valid exactly one cycle after the strobe
	task automatic port_read(input logic [15:0] addr, output zbyte_t val);
		io_rd = 1'b1;
		a = addr;
		@(posedge fclk);
		#1;
		io_rd = 1'b0;
		check_bit("dout_ena", 1'b1, dout_ena);
		val = dout;
		@(posedge fclk);
		#1;
		check_bit("dout_ena", 1'b0, dout_ena);
	endtask

	task automatic wait_idle();
		zbyte_t st;
		int     polls;
		polls = 0;
		st = 8'h01;
		while (st[STAT_BUSY_BIT]) begin
			if (polls == POLL_LIMIT)
				stop_run("link stayed busy too long");
			port_read({8'h00, SD_CTRL_PORT}, st);
			polls++;
		end
		check_state("spi_master.state", SPI_IDLE, uut.spi_master.state);
	endtask

	task automatic expect_sent(input zbyte_t exp);
		int waited;
		waited = 0;
		while (tx_q.size() == 0) begin
			if (waited == POLL_LIMIT)
				stop_run("no byte was sent on sddo");
			@(posedge fclk);
			#1;
			waited++;
		end
		check_byte("sddo byte", exp, tx_q.pop_front());
	endtask

	task automatic run_burst(input zbyte_t exp_status);
		zbyte_t sent [TB_FIFO_DEPTH+3];
		zbyte_t st;
		for (int i = 0; i < TB_FIFO_DEPTH + 3; i++) begin
			lcg_state = lcg_next(lcg_state);
			sent[i] = lcg_state[23:16];
		end
		// consecutive writes with no idle cycle between them
		io_wr = 1'b1;
		a = {8'h00, SD_DATA_PORT};
		for (int i = 0; i < TB_FIFO_DEPTH + 3; i++) begin
			din = sent[i];
			@(posedge fclk);
			#1;
		end
		io_wr = 1'b0;
		for (int i = 0; i < TB_FIFO_DEPTH + 1; i++)
			expect_sent(sent[i]);
		wait_idle();
		if (tx_q.size() != 0)
			stop_run("burst sent more bytes than the FIFO could accept");
		port_read({8'h00, SD_CTRL_PORT}, st);
		check_byte("status", exp_status, st);
	endtask

	initial begin
		zbyte_t kind;
		zbyte_t val;
		zbyte_t exp;
		zbyte_t got;
		fclk = 1'b0;
		rst_n = 1'b0;
		io_wr = 1'b0;
		io_rd = 1'b0;
		a = '0;
		din = '0;
		rx_shift = '0;
		rx_cnt = 0;
		reply = 8'hA5;
		sddi = reply[7];
		lcg_state = 32'h43fc4fe1;
		recs_loaded = 1'b0;
		for (int i = 0; i < 3*MAX_RECS; i++)
			recs[i] = '0;
		$readmemh("verification/sd_spi_input.txt", recs);
		n_recs = 0;
		while (n_recs < MAX_RECS && recs[3*n_recs] != 8'h00)
			n_recs++;
		if (n_recs == 0)
			stop_run("input file held no records");
		recs_loaded = 1'b1;

		repeat (16) @(posedge fclk);
		#1;
		rst_n = 1'b1;
		check_bit("sdcs_n", 1'b1, sdcs_n);
		check_bit("sdclk", 1'b0, sdclk);
		check_bit("dout_ena", 1'b0, dout_ena);

		for (int r = 0; r < n_recs; r++) begin
			kind = recs[3*r];
			val = recs[3*r+1];
			exp = recs[3*r+2];
			case (int'(kind))
				int'(PORT_DATA_WR): port_write({8'h00, SD_DATA_PORT}, val);
				int'(PORT_DATA_RD): begin
					port_read({8'h00, SD_DATA_PORT}, got);
					check_byte("dout", exp, got);
				end
				int'(PORT_CTRL_WR): begin
					port_write({8'h00, SD_CTRL_PORT}, val);
					check_bit("sdcs_n", exp[0], sdcs_n);
				end
				int'(PORT_CTRL_RD): begin
					port_read({8'h00, SD_CTRL_PORT}, got);
					check_byte("status", exp, got);
				end
				K_BURST: run_burst(exp);
				K_IDLE: wait_idle();
				K_TX: expect_sent(exp);
				K_STAT_HI: begin
					port_read({val, SD_CTRL_PORT}, got);
					check_byte("status", exp, got);
				end
				default: stop_run($sformatf("unknown record kind %h in line %0d", kind, r));
			endcase
		end

		$display("All tests passed");
		$finish;
	end

	// budget of 64 cycles per record plus margin
	initial begin
		wait (recs_loaded);
		#(n_recs * 64 * 10 + 2000);
		stop_run("watchdog expired before the tests finished");
	end

endmodule
